/* Bender.yml */
package:
  name: fc_layer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/fc_pkg.sv
      - source/mem_req_if.sv
      - source/word_sram.sv
      - source/buffer_arbiter.sv
      - source/signed_mac.sv
      - source/stream_loader.sv
      - source/mac_engine.sv
      - source/fc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_fc_top.sv

/* include/fc_defs.svh */
`ifndef FC_DEFS_SVH
`define FC_DEFS_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////

`define FC_DATA_W          32   // stream and buffer word
`define FC_ADDR_W          9
`define FC_MEM_DEPTH       512
`define FC_LANES           4    // output neurons, one byte each per word
`define FC_SIZE_W          7    // holds 1 .. 64

////////////////////////////////////////
// buffer memory map
////////////////////////////////////////

// longest feature vector in words, also the weight row stride
`define FC_MAX_FEAT_WORDS  64

`define FC_FEAT_BASE       0
`define FC_BIAS_ADDR       64
`define FC_WEIGHT_BASE     128  // row r starts at base + r * stride

`endif

/* project.f */
+incdir+include
source/fc_pkg.sv
source/mem_req_if.sv
source/word_sram.sv
source/buffer_arbiter.sv
source/signed_mac.sv
source/stream_loader.sv
source/mac_engine.sv
source/fc_top.sv
verification/tb_fc_top.sv

/* source/buffer_arbiter.sv */
`timescale 1ns/1ps

module buffer_arbiter (
  input  logic       clk,
  input  logic       rstn,
  mem_req_if.arbiter ld,
  mem_req_if.arbiter en
);

  logic          ram_en;
  logic          ram_we;
  fc_pkg::addr_t ram_addr;
  fc_pkg::word_t ram_wdata;
  fc_pkg::word_t ram_rdata;
  logic          rd_ld;  // last read was issued by the loader

  // loader wins, engine gets the leftover cycles
  assign ld.gnt = ld.req;
  assign en.gnt = en.req & ~ld.req;

  assign ram_en    = ld.req | en.req;
  assign ram_we    = ld.req ? ld.we    : en.we;
  assign ram_addr  = ld.req ? ld.addr  : en.addr;
  assign ram_wdata = ld.req ? ld.wdata : en.wdata;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_ld <= 1'b0;
    end else if (ram_en && !ram_we) begin
      rd_ld <= ld.req;
    end
  end

  // steer read data back to its owner
  assign ld.rdata = rd_ld ? ram_rdata : '0;
  assign en.rdata = rd_ld ? '0 : ram_rdata;

  word_sram u_sram (
    .clk   (clk),
    .we    (ram_we),
    .en    (ram_en),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

endmodule

/* source/fc_pkg.sv */
`include "fc_defs.svh"

package fc_pkg;

  // four signed bytes, lane 0 in the low byte
  typedef logic [`FC_LANES-1:0][`FC_DATA_W/`FC_LANES-1:0] word_t;

  typedef logic [`FC_ADDR_W-1:0] addr_t;

  typedef logic signed [`FC_DATA_W-1:0] acc_t;

  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_LOAD_FEATURE,
    CMD_LOAD_BIAS,
    CMD_LOAD_WEIGHT,
    CMD_COMPUTE
  } cmd_e;

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_RECEIVE,
    LD_DONE
  } loader_state_e;

  typedef enum logic [2:0] {
    EN_IDLE,
    EN_READ_FEAT,
    EN_READ_WEIGHT,
    EN_DRAIN,       // let the lane pipelines settle
    EN_READ_BIAS,
    EN_SEND
  } engine_state_e;

endpackage

/* source/fc_top.sv */
`timescale 1ns/1ps
`include "fc_defs.svh"

module fc_top (
  input  logic                  clk,
  input  logic                  rstn,
  input  fc_pkg::cmd_e          cmd,
  input  logic                  cmd_valid,
  input  logic [`FC_SIZE_W-1:0] size,
  input  logic [`FC_DATA_W-1:0] s_axis_tdata,
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  logic                  s_axis_tlast,
  output logic [`FC_DATA_W-1:0] m_axis_tdata,
  output logic                  m_axis_tvalid,
  input  logic                  m_axis_tready,
  output logic                  m_axis_tlast,
  output logic                  load_done,
  output logic                  fc_done
);

  mem_req_if ld_bus ();  // loader side
  mem_req_if en_bus ();  // engine side

  stream_loader u_loader (
    .clk           (clk),
    .rstn          (rstn),
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .size          (size),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tlast  (s_axis_tlast),
    .load_done     (load_done),
    .mem           (ld_bus.requester)
  );

  mac_engine u_engine (
    .clk           (clk),
    .rstn          (rstn),
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .size          (size),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .fc_done       (fc_done),
    .mem           (en_bus.requester)
  );

  buffer_arbiter u_arbiter (
    .clk  (clk),
    .rstn (rstn),
    .ld   (ld_bus.arbiter),
    .en   (en_bus.arbiter)
  );

endmodule

/* source/mac_engine.sv */
`timescale 1ns/1ps
`include "fc_defs.svh"

module mac_engine (
  input  logic                  clk,
  input  logic                  rstn,
  input  fc_pkg::cmd_e          cmd,
  input  logic                  cmd_valid,
  input  logic [`FC_SIZE_W-1:0] size,
  output logic [`FC_DATA_W-1:0] m_axis_tdata,
  output logic                  m_axis_tvalid,
  input  logic                  m_axis_tready,
  output logic                  m_axis_tlast,
  output logic                  fc_done,
  mem_req_if.requester          mem
);

  fc_pkg::engine_state_e state;
  logic [`FC_SIZE_W-1:0] size_q;
  logic [`FC_SIZE_W-1:0] idx;        // feature word index
  logic [1:0]            lane;       // weight row while reading, result while sending
  logic                  drain;
  logic                  rd_feat;    // read data due this cycle, by kind
  logic                  rd_weight;
  logic                  rd_bias;
  logic                  rd_first;
  logic [1:0]            rd_lane;
  fc_pkg::word_t         feat_q;
  fc_pkg::acc_t          lane_acc [`FC_LANES];
  fc_pkg::acc_t          res [`FC_LANES];
  logic                  last_idx;
  logic                  send_ok;

  assign last_idx = (idx == size_q - 1'b1);
  assign send_ok  = m_axis_tvalid && m_axis_tready;

  ////////////////////////////////////////
  // buffer read requests
  ////////////////////////////////////////

  always_comb begin
    mem.req  = 1'b0;
    mem.addr = '0;
    case (state)
      fc_pkg::EN_READ_FEAT: begin
        mem.req  = 1'b1;
        mem.addr = fc_pkg::addr_t'(`FC_FEAT_BASE + idx);
      end
      fc_pkg::EN_READ_WEIGHT: begin
        mem.req  = 1'b1;
        mem.addr = fc_pkg::addr_t'(`FC_WEIGHT_BASE + lane * `FC_MAX_FEAT_WORDS + idx);
      end
      fc_pkg::EN_READ_BIAS: begin
        mem.req  = 1'b1;
        mem.addr = fc_pkg::addr_t'(`FC_BIAS_ADDR);
      end
      default: ;
    endcase
  end

  assign mem.we    = 1'b0;  // read only
  assign mem.wdata = '0;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state         <= fc_pkg::EN_IDLE;
      rd_feat       <= 1'b0;
      rd_weight     <= 1'b0;
      rd_bias       <= 1'b0;
      m_axis_tvalid <= 1'b0;
      fc_done       <= 1'b0;
    end else begin
      rd_feat   <= (state == fc_pkg::EN_READ_FEAT) && mem.gnt;
      rd_weight <= (state == fc_pkg::EN_READ_WEIGHT) && mem.gnt;
      rd_bias   <= (state == fc_pkg::EN_READ_BIAS) && mem.gnt;
      fc_done   <= 1'b0;
      case (state)
        fc_pkg::EN_IDLE:
          if (cmd_valid && cmd == fc_pkg::CMD_COMPUTE) state <= fc_pkg::EN_READ_FEAT;
        fc_pkg::EN_READ_FEAT:
          if (mem.gnt) state <= fc_pkg::EN_READ_WEIGHT;
        fc_pkg::EN_READ_WEIGHT:
          if (mem.gnt && lane == 2'd3) begin
            state <= last_idx ? fc_pkg::EN_DRAIN : fc_pkg::EN_READ_FEAT;
          end
        fc_pkg::EN_DRAIN:
          if (drain) state <= fc_pkg::EN_READ_BIAS;
        fc_pkg::EN_READ_BIAS:
          if (mem.gnt) state <= fc_pkg::EN_SEND;
        fc_pkg::EN_SEND: begin
          if (rd_bias) begin
            m_axis_tvalid <= 1'b1;  // results land with the bias word
          end else if (send_ok && lane == 2'd3) begin
            m_axis_tvalid <= 1'b0;
            fc_done       <= 1'b1;
            state         <= fc_pkg::EN_IDLE;
          end
        end
        default: state <= fc_pkg::EN_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    rd_lane  <= lane;
    rd_first <= (idx == '0);  // first index restarts the sums
    if (rd_feat) feat_q <= mem.rdata;
    if (rd_bias) begin
      for (int l = 0; l < `FC_LANES; l++) begin
        res[l] <= lane_acc[l] + $signed(mem.rdata[l]);  // bias byte sign extended
      end
    end
    case (state)
      fc_pkg::EN_IDLE: begin
        size_q <= size;
        idx    <= '0;
        lane   <= '0;
        drain  <= 1'b0;
      end
      fc_pkg::EN_READ_WEIGHT:
        if (mem.gnt) begin
          lane <= lane + 1'b1;  // wraps to lane 0 after row 3
          if (lane == 2'd3 && !last_idx) idx <= idx + 1'b1;
        end
      fc_pkg::EN_DRAIN: drain <= 1'b1;
      fc_pkg::EN_SEND:  if (send_ok) lane <= lane + 1'b1;
      default: ;
    endcase
  end

  assign m_axis_tdata = res[lane];
  assign m_axis_tlast = m_axis_tvalid && (lane == 2'd3);

  for (genvar l = 0; l < `FC_LANES; l++) begin : g_lane
    signed_mac u_mac (
      .clk    (clk),
      .rstn   (rstn),
      .valid  (rd_weight && rd_lane == 2'(l)),
      .clear  (rd_first),
      .feat   (feat_q),
      .weight (mem.rdata),
      .acc    (lane_acc[l])
    );
  end

endmodule

/* source/mem_req_if.sv */
`timescale 1ns/1ps

// one requester port on the shared word buffer
interface mem_req_if;

  logic          req;
  logic          we;
  fc_pkg::addr_t addr;
  fc_pkg::word_t wdata;
  logic          gnt;    // same cycle as req
  fc_pkg::word_t rdata;  // one cycle after a granted read

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

/* source/signed_mac.sv */
`timescale 1ns/1ps
`include "fc_defs.svh"

module signed_mac (
  input  logic          clk,
  input  logic          rstn,
  input  logic          valid,
  input  logic          clear,
  input  fc_pkg::word_t feat,
  input  fc_pkg::word_t weight,
  output fc_pkg::acc_t  acc
);

  logic [7:0]   f_mag [`FC_LANES];
  logic [7:0]   w_mag [`FC_LANES];
  logic [15:0]  mag_q [`FC_LANES];  // unsigned byte products
  logic [`FC_LANES-1:0] neg_q;
  logic         v_q;
  logic         clr_q;
  fc_pkg::acc_t sum;

  ////////////////////////////////////////
  // stage one, sign and magnitude products
  ////////////////////////////////////////

  always_comb begin
    for (int b = 0; b < `FC_LANES; b++) begin
      f_mag[b] = feat[b][7] ? ~feat[b] + 8'd1 : feat[b];  // -128 gives 8'h80
      w_mag[b] = weight[b][7] ? ~weight[b] + 8'd1 : weight[b];
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < `FC_LANES; b++) begin
      mag_q[b] <= f_mag[b] * w_mag[b];
      neg_q[b] <= feat[b][7] ^ weight[b][7];
    end
    clr_q <= clear;
  end

  always_ff @(posedge clk) begin
    if (!rstn) v_q <= 1'b0;
    else       v_q <= valid;
  end

  ////////////////////////////////////////
  // stage two, signed sum and accumulate
  ////////////////////////////////////////

  always_comb begin
    sum = '0;
    for (int b = 0; b < `FC_LANES; b++) begin
      sum = sum + (neg_q[b] ? -fc_pkg::acc_t'(mag_q[b]) : fc_pkg::acc_t'(mag_q[b]));
    end
  end

  always_ff @(posedge clk) begin
    if (v_q) acc <= (clr_q ? fc_pkg::acc_t'(0) : acc) + sum;
  end

endmodule

/* source/stream_loader.sv */
`timescale 1ns/1ps
`include "fc_defs.svh"

module stream_loader (
  input  logic                  clk,
  input  logic                  rstn,
  input  fc_pkg::cmd_e          cmd,
  input  logic                  cmd_valid,
  input  logic [`FC_SIZE_W-1:0] size,
  input  logic [`FC_DATA_W-1:0] s_axis_tdata,
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  logic                  s_axis_tlast,
  output logic                  load_done,
  mem_req_if.requester          mem
);

  fc_pkg::loader_state_e state;
  fc_pkg::addr_t         addr;        // next write address
  fc_pkg::addr_t         row_base;    // first word of the current weight row
  fc_pkg::addr_t         start_addr;
  logic [`FC_SIZE_W-1:0] size_q;
  logic [`FC_SIZE_W-1:0] col;
  logic                  wt_mode;     // rows of size words
  logic                  is_load;
  logic                  start;
  logic                  accept;

  // start address per load opcode
  always_comb begin
    is_load    = 1'b1;
    start_addr = fc_pkg::addr_t'(`FC_FEAT_BASE);
    case (cmd)
      fc_pkg::CMD_LOAD_FEATURE: start_addr = fc_pkg::addr_t'(`FC_FEAT_BASE);
      fc_pkg::CMD_LOAD_BIAS:    start_addr = fc_pkg::addr_t'(`FC_BIAS_ADDR);
      fc_pkg::CMD_LOAD_WEIGHT:  start_addr = fc_pkg::addr_t'(`FC_WEIGHT_BASE);
      default:                  is_load    = 1'b0;
    endcase
  end

  assign start = (state == fc_pkg::LD_IDLE) && cmd_valid && is_load;

  ////////////////////////////////////////
  // buffer writes, stall on a refused grant
  ////////////////////////////////////////

  assign mem.req   = (state == fc_pkg::LD_RECEIVE) && s_axis_tvalid;
  assign mem.we    = 1'b1;
  assign mem.addr  = addr;
  assign mem.wdata = s_axis_tdata;

  assign s_axis_tready = (state == fc_pkg::LD_RECEIVE) && (!s_axis_tvalid || mem.gnt);
  assign accept        = s_axis_tvalid && s_axis_tready;
  assign load_done     = (state == fc_pkg::LD_DONE);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= fc_pkg::LD_IDLE;
    end else begin
      case (state)
        fc_pkg::LD_IDLE:    if (start) state <= fc_pkg::LD_RECEIVE;
        fc_pkg::LD_RECEIVE: if (accept && s_axis_tlast) state <= fc_pkg::LD_DONE;
        default:            state <= fc_pkg::LD_IDLE;  // done lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      addr     <= start_addr;
      row_base <= start_addr;
      col      <= '0;
      size_q   <= size;
      wt_mode  <= (cmd == fc_pkg::CMD_LOAD_WEIGHT);
    end else if (accept) begin
      if (wt_mode && col == size_q - 1'b1) begin
        // end of a weight row, jump by the row stride
        col      <= '0;
        row_base <= row_base + fc_pkg::addr_t'(`FC_MAX_FEAT_WORDS);
        addr     <= row_base + fc_pkg::addr_t'(`FC_MAX_FEAT_WORDS);
      end else begin
        col  <= col + 1'b1;
        addr <= addr + 1'b1;
      end
    end
  end

endmodule

/* source/word_sram.sv */
`timescale 1ns/1ps
`include "fc_defs.svh"

module word_sram (
  input  logic          clk,
  input  logic          we,
  input  logic          en,
  input  fc_pkg::addr_t addr,
  input  fc_pkg::word_t wdata,
  output fc_pkg::word_t rdata
);

  fc_pkg::word_t mem [`FC_MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];  // old contents on a write cycle
    end
  end

endmodule

/* verification/tb_fc_top.sv */
`timescale 1ns/1ps
`include "fc_defs.svh"

module tb_fc_top;

  // two full loads, one reload of five features and four result bursts
  localparam int FULL_LOAD      = `FC_MAX_FEAT_WORDS * (1 + `FC_LANES) + 1;
  localparam int STREAM_WORDS   = 2 * FULL_LOAD + 5 + 4 * `FC_LANES;
  localparam int TIMEOUT_CYCLES = 200 * STREAM_WORDS + 2000;

  logic                  clk = 1'b0;
  logic                  rstn;
  fc_pkg::cmd_e          cmd;
  logic                  cmd_valid;
  logic [`FC_SIZE_W-1:0] size;
  logic [`FC_DATA_W-1:0] s_axis_tdata;
  logic                  s_axis_tvalid;
  logic                  s_axis_tready;
  logic                  s_axis_tlast;
  logic [`FC_DATA_W-1:0] m_axis_tdata;
  logic                  m_axis_tvalid;
  logic                  m_axis_tready;
  logic                  m_axis_tlast;
  logic                  load_done;
  logic                  fc_done;

  // host side copy of the buffer contents
  logic [`FC_DATA_W-1:0] feat_m [`FC_MAX_FEAT_WORDS];
  logic [`FC_DATA_W-1:0] bias_m;
  logic [`FC_DATA_W-1:0] wt_m [`FC_LANES][`FC_MAX_FEAT_WORDS];
  logic signed [31:0]    exp_res [`FC_LANES];

  logic                  rand_ready = 1'b0;
  int                    errors = 0;
  int                    results_seen = 0;
  int                    done_seen = 0;
  logic                  done_due = 1'b0;   // fc_done expected this cycle
  logic                  stall_q = 1'b0;
  logic [`FC_DATA_W-1:0] data_q;
  logic                  last_q;

  fc_top i_dut (
    .clk           (clk),
    .rstn          (rstn),
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .size          (size),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tlast  (s_axis_tlast),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .load_done     (load_done),
    .fc_done       (fc_done)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // reference model and checking
  ////////////////////////////////////////

  function automatic logic signed [31:0] fc_expected(
    input logic [`FC_DATA_W-1:0] feat [`FC_MAX_FEAT_WORDS],
    input logic [`FC_DATA_W-1:0] bias,
    input logic [`FC_DATA_W-1:0] wt [`FC_LANES][`FC_MAX_FEAT_WORDS],
    input int                    lane,
    input int                    n
  );
    int                sum;
    logic signed [7:0] fb;
    logic signed [7:0] wb;
    sum = int'($signed(bias[8*lane +: 8]));
    for (int i = 0; i < n; i++) begin
      for (int b = 0; b < `FC_LANES; b++) begin
        fb  = feat[i][8*b +: 8];
        wb  = wt[lane][i][8*b +: 8];
        sum = sum + int'(fb) * int'(wb);
      end
    end
    return sum;
  endfunction

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what,
               $signed(actual), $signed(expected));
      $display("Simulation FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // output stream monitor sampled mid cycle
  always @(negedge clk) begin
    if (rstn) begin
      if (stall_q) begin
        check_value("tvalid under back-pressure", m_axis_tvalid, 1);
        check_value("tdata under back-pressure", m_axis_tdata, data_q);
        check_value("tlast under back-pressure", m_axis_tlast, last_q);
      end
      check_value("fc_done", fc_done, done_due);
      if (fc_done) done_seen++;
      done_due = 1'b0;
      if (m_axis_tvalid && m_axis_tready) begin
        check_value("result", m_axis_tdata, exp_res[results_seen % `FC_LANES]);
        check_value("tlast", m_axis_tlast, (results_seen % `FC_LANES) == 3);
        done_due = ((results_seen % `FC_LANES) == 3);  // pulse follows the last result
        results_seen++;
      end
      stall_q = m_axis_tvalid && !m_axis_tready;
      data_q  = m_axis_tdata;
      last_q  = m_axis_tlast;
    end
  end

  always @(posedge clk) begin
    #1;
    m_axis_tready = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, the DUT stopped responding", TIMEOUT_CYCLES);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////

  task automatic issue_cmd(input fc_pkg::cmd_e op, input int n);
    cmd       = op;
    size      = n[`FC_SIZE_W-1:0];  // held after the command
    cmd_valid = 1'b1;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    cmd       = fc_pkg::CMD_NONE;
  endtask

  task automatic send_word(input logic [`FC_DATA_W-1:0] data, input logic last);
    logic ok;
    s_axis_tdata  = data;
    s_axis_tlast  = last;
    s_axis_tvalid = 1'b1;
    do begin
      @(negedge clk);
      ok = s_axis_tready;
      @(posedge clk);
      #1;
    end while (!ok);
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
  endtask

  task automatic wait_load_done();
    do @(negedge clk); while (!load_done);
    @(posedge clk);
    #1;
  endtask

  task automatic load_features(input int n);
    issue_cmd(fc_pkg::CMD_LOAD_FEATURE, n);
    for (int i = 0; i < n; i++) send_word(feat_m[i], i == n - 1);
    wait_load_done();
  endtask

  task automatic load_bias();
    issue_cmd(fc_pkg::CMD_LOAD_BIAS, 1);
    send_word(bias_m, 1'b1);
    wait_load_done();
  endtask

  task automatic load_weights(input int n);
    issue_cmd(fc_pkg::CMD_LOAD_WEIGHT, n);
    for (int r = 0; r < `FC_LANES; r++) begin
      for (int i = 0; i < n; i++) send_word(wt_m[r][i], r == `FC_LANES - 1 && i == n - 1);
    end
    wait_load_done();
  endtask

  task automatic run_compute(input int n);
    int done_target;
    int res_target;
    for (int l = 0; l < `FC_LANES; l++) exp_res[l] = fc_expected(feat_m, bias_m, wt_m, l, n);
    done_target = done_seen + 1;
    res_target  = results_seen + `FC_LANES;
    issue_cmd(fc_pkg::CMD_COMPUTE, n);
    while (done_seen < done_target) @(posedge clk);
    #1;
    check_value("results per compute", results_seen, res_target);
  endtask

  function automatic logic [`FC_DATA_W-1:0] edge_word();
    logic [`FC_DATA_W-1:0] w;
    for (int b = 0; b < `FC_LANES; b++) w[8*b +: 8] = $urandom_range(0, 1) ? 8'h80 : 8'h7f;
    return w;
  endfunction

  initial begin
    void'($urandom(36586));
    rstn          = 1'b0;
    cmd           = fc_pkg::CMD_NONE;
    cmd_valid     = 1'b0;
    size          = '0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b1;
    repeat (8) @(posedge clk);
    #1 rstn = 1'b1;

    // idle outputs after reset
    @(negedge clk);
    check_value("s_axis_tready after reset", s_axis_tready, 0);
    check_value("m_axis_tvalid after reset", m_axis_tvalid, 0);
    check_value("m_axis_tlast after reset", m_axis_tlast, 0);
    check_value("load_done after reset", load_done, 0);
    check_value("fc_done after reset", fc_done, 0);
    @(posedge clk);
    #1;

    for (int i = 0; i < `FC_MAX_FEAT_WORDS; i++) feat_m[i] = $urandom();
    bias_m = $urandom();
    for (int r = 0; r < `FC_LANES; r++) begin
      for (int i = 0; i < `FC_MAX_FEAT_WORDS; i++) wt_m[r][i] = $urandom();
    end
    load_features(`FC_MAX_FEAT_WORDS);
    load_bias();
    load_weights(`FC_MAX_FEAT_WORDS);
    run_compute(`FC_MAX_FEAT_WORDS);

    rand_ready = 1'b1;  // same layer under back-pressure
    run_compute(`FC_MAX_FEAT_WORDS);
    rand_ready = 1'b0;

    // short vector over the bias and weights already in place
    for (int i = 0; i < 5; i++) feat_m[i] = $urandom();
    load_features(5);
    run_compute(5);

    for (int i = 0; i < `FC_MAX_FEAT_WORDS; i++) feat_m[i] = edge_word();
    bias_m = edge_word();
    for (int r = 0; r < `FC_LANES; r++) begin
      for (int i = 0; i < `FC_MAX_FEAT_WORDS; i++) wt_m[r][i] = edge_word();
    end
    load_features(`FC_MAX_FEAT_WORDS);
    load_bias();
    load_weights(`FC_MAX_FEAT_WORDS);
    run_compute(`FC_MAX_FEAT_WORDS);

    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
